// File: periph_map_pkg.sv
// ---------------------------------------------------------------------------
// Register word addresses, reset values and sizes of the peripheral subsystem
// ---------------------------------------------------------------------------

`default_nettype none

package periph_map_pkg;

    // ---------------------------------------------------------------------------
    // Register map, word addresses taken from byte address bits 7:2
    // ---------------------------------------------------------------------------
    localparam logic [5:0] REG_SCRATCH        = 6'd0;
    localparam logic [5:0] REG_BOOTVEC        = 6'd1;
    localparam logic [5:0] REG_GPIO_DIR       = 6'd2;
    localparam logic [5:0] REG_GPIO_WRITE     = 6'd3;
    localparam logic [5:0] REG_GPIO_READ      = 6'd4;   // Read-only
    localparam logic [5:0] REG_UART_PRESCALER = 6'd5;
    localparam logic [5:0] REG_UART_STATUS    = 6'd6;   // Read-only
    localparam logic [5:0] REG_UART_CTRL      = 6'd7;   // Bit 0 clears the TX FIFO
    localparam logic [5:0] REG_UART_TXDATA    = 6'd8;   // Write-only

    // ---------------------------------------------------------------------------
    // Reset values and sizes
    // ---------------------------------------------------------------------------
    // 115200 baud from a 24 MHz clock
    localparam logic [15:0] PRESCALER_RESET = 16'd207;

    localparam int GPIO_WIDTH = 16;

    // TX FIFO, depth must be a power of two
    localparam int UART_FIFO_DEPTH = 16;
    localparam int UART_FIFO_AW    = 4;

endpackage

`default_nettype wire

// File: periph_types_pkg.sv
// ---------------------------------------------------------------------------
// Packed structs for the bus request, GPIO and UART control and UART status
// ---------------------------------------------------------------------------

`default_nettype none

package periph_types_pkg;

    // Bus request from the master, classic strobe/ack cycle
    typedef struct packed {
        logic [7:0]  adr;   // Byte address, bits 1:0 ignored
        logic [31:0] dat;
        logic        we;
        logic        stb;
    } bus_req_t;

    // Pad control
    typedef struct packed {
        logic [periph_map_pkg::GPIO_WIDTH-1:0] dir;     // 1 drives the pin
        logic [periph_map_pkg::GPIO_WIDTH-1:0] write;
    } gpio_ctrl_t;

    // Register block to FIFO and transmitter
    typedef struct packed {
        logic [15:0] prescaler;
        logic        tx_clear;  // One-shot
        logic        tx_push;   // One-shot
        logic [7:0]  tx_data;
    } uart_ctrl_t;

    // FIFO back to the register block
    typedef struct packed {
        logic [15:0] tx_size;
        logic        tx_full;
        logic        tx_empty;
    } uart_status_t;

endpackage

`default_nettype wire

// File: periph_gpreg.sv
// ---------------------------------------------------------------------------
// General purpose register block, bus slave with registered-feedback ack
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_gpreg (
    input  logic                                  clk,
    input  logic                                  rstz,
    input  periph_types_pkg::bus_req_t            bus_req_i,
    output logic [31:0]                           gpreg_dat_o,
    output logic                                  gpreg_ack_o,
    output periph_types_pkg::gpio_ctrl_t          gpio_ctrl_o,
    input  logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_read_i,
    output periph_types_pkg::uart_ctrl_t          uart_ctrl_o,
    input  periph_types_pkg::uart_status_t        uart_status_i,
    output logic [23:0]                           bootvec_o
);
    import periph_map_pkg::*;

    logic [5:0]            addr;
    logic                  access;
    logic                  ack;

    logic [31:0]           scratch;
    logic [23:0]           bootvec;
    logic [GPIO_WIDTH-1:0] gpio_dir;
    logic [GPIO_WIDTH-1:0] gpio_write;
    logic [15:0]           prescaler;
    logic                  tx_clear;
    logic                  tx_push;
    logic [7:0]            tx_data;

    assign addr   = bus_req_i.adr[7:2];    // Word aligned
    assign access = bus_req_i.stb & ~ack;  // New strobe, not yet acked

    // ---------------------------------------------------------------------------
    // Register writes and one-shots
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            scratch    <= '0;
            bootvec    <= '0;
            gpio_dir   <= '0;               // All pins inputs
            gpio_write <= '0;
            prescaler  <= PRESCALER_RESET;
            tx_clear   <= 1'b0;
            tx_push    <= 1'b0;
        end else if (access && bus_req_i.we) begin
            case (addr)
                REG_SCRATCH:        scratch    <= bus_req_i.dat;
                REG_BOOTVEC:        bootvec    <= bus_req_i.dat[23:0];
                REG_GPIO_DIR:       gpio_dir   <= bus_req_i.dat[GPIO_WIDTH-1:0];
                REG_GPIO_WRITE:     gpio_write <= bus_req_i.dat[GPIO_WIDTH-1:0];
                REG_UART_PRESCALER: prescaler  <= bus_req_i.dat[15:0];
                REG_UART_CTRL:      tx_clear   <= bus_req_i.dat[0];
                REG_UART_TXDATA:    tx_push    <= 1'b1;
                default: ;                  // Read-only or unmapped
            endcase
        end else if (ack) begin
            // One-shots last only for the ack cycle
            tx_clear <= 1'b0;
            tx_push  <= 1'b0;
        end
    end

    // Byte for the FIFO, qualified by tx_push
    always_ff @(posedge clk) begin
        if (access && bus_req_i.we && (addr == REG_UART_TXDATA))
            tx_data <= bus_req_i.dat[7:0];
    end

    // ---------------------------------------------------------------------------
    // Registered reads, data holds until the next read
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (access && !bus_req_i.we) begin
            case (addr)
                REG_SCRATCH:        gpreg_dat_o <= scratch;
                REG_BOOTVEC:        gpreg_dat_o <= {8'h0, bootvec};
                REG_GPIO_DIR:       gpreg_dat_o <= 32'(gpio_dir);
                REG_GPIO_WRITE:     gpreg_dat_o <= 32'(gpio_write);
                REG_GPIO_READ:      gpreg_dat_o <= 32'(gpio_read_i);
                REG_UART_PRESCALER: gpreg_dat_o <= {16'h0, prescaler};
                REG_UART_STATUS:    gpreg_dat_o <= {14'h0, uart_status_i.tx_full,
                                                    uart_status_i.tx_empty,
                                                    uart_status_i.tx_size};
                default: ;                  // Write-only or unmapped keeps data
            endcase
        end
    end

    // Ack one cycle after the strobe is sampled
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) ack <= 1'b0;
        else       ack <= access;
    end

    assign gpreg_ack_o = ack;
    assign bootvec_o   = bootvec;

    assign gpio_ctrl_o.dir   = gpio_dir;
    assign gpio_ctrl_o.write = gpio_write;

    assign uart_ctrl_o.prescaler = prescaler;
    assign uart_ctrl_o.tx_clear  = tx_clear;
    assign uart_ctrl_o.tx_push   = tx_push;
    assign uart_ctrl_o.tx_data   = tx_data;

endmodule

`default_nettype wire

// File: periph_gpio.sv
// ---------------------------------------------------------------------------
// GPIO pads, registered enables and outputs, two-flop input synchronizer
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_gpio (
    input  logic                                  clk,
    input  logic                                  rstz,
    input  periph_types_pkg::gpio_ctrl_t          gpio_ctrl_i,
    input  logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
    output logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_out_o,
    output logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_read_o
);
    import periph_map_pkg::*;

    logic [GPIO_WIDTH-1:0] sync_q1;
    logic [GPIO_WIDTH-1:0] sync_q2;

    // Pad drivers, updated on the edge that ends the write's ack cycle
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            gpio_oe_o  <= '0;   // Pads released
            gpio_out_o <= '0;
        end else begin
            gpio_oe_o  <= gpio_ctrl_i.dir;
            gpio_out_o <= gpio_ctrl_i.write;
        end
    end

    // Pad inputs are asynchronous to clk
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
        end
    end

    assign gpio_read_o = sync_q2;

endmodule

`default_nettype wire

// File: periph_uart_fifo.sv
// ---------------------------------------------------------------------------
// UART transmit FIFO, byte wide, with occupancy count and clear
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_uart_fifo (
    input  logic                           clk,
    input  logic                           rstz,
    input  periph_types_pkg::uart_ctrl_t   uart_ctrl_i,
    input  logic                           pop_i,
    output logic [7:0]                     head_o,
    output periph_types_pkg::uart_status_t uart_status_o
);
    import periph_map_pkg::*;

    logic [7:0]              mem [UART_FIFO_DEPTH];
    logic [UART_FIFO_AW-1:0] wptr;
    logic [UART_FIFO_AW-1:0] rptr;
    logic [UART_FIFO_AW:0]   count;     // One bit wider to hold DEPTH
    logic                    full;
    logic                    empty;
    logic                    push_ok;
    logic                    pop_ok;

    assign full    = (count == (UART_FIFO_AW+1)'(UART_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign push_ok = uart_ctrl_i.tx_push & ~full;   // Push on full is dropped
    assign pop_ok  = pop_i & ~empty;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (uart_ctrl_i.tx_clear) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push_ok) wptr <= wptr + 1'b1;   // Wraps at DEPTH
            if (pop_ok)  rptr <= rptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_ok) mem[wptr] <= uart_ctrl_i.tx_data;
    end

    assign head_o = mem[rptr];

    assign uart_status_o.tx_size  = 16'(count);
    assign uart_status_o.tx_full  = full;
    assign uart_status_o.tx_empty = empty;

endmodule

`default_nettype wire

// File: periph_uart_tx.sv
// ---------------------------------------------------------------------------
// UART 8N1 transmitter with prescaled bit tick, fed from the TX FIFO
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_uart_tx (
    input  logic        clk,
    input  logic        rstz,
    input  logic [15:0] prescaler_i,
    input  logic        fifo_empty_i,
    input  logic [7:0]  head_i,
    output logic        pop_o,
    output logic        uart_tx_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} tx_state_t;

    tx_state_t   state;
    logic [15:0] presc_q;   // Bit time for the current frame
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;
    logic        tick;
    logic        load;

    assign tick  = (cnt == presc_q);
    // Start a frame from idle, or straight after a stop bit
    assign load  = ~fifo_empty_i & ((state == ST_IDLE) | ((state == ST_STOP) & tick));
    assign pop_o = load;

    // ---------------------------------------------------------------------------
    // Bit timing, prescaler+1 cycles per bit
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            cnt     <= '0;
            presc_q <= '0;
        end else if (load) begin
            cnt     <= '0;
            presc_q <= prescaler_i;
        end else if (state == ST_IDLE || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 16'd1;
        end
    end

    // ---------------------------------------------------------------------------
    // Frame FSM, start bit, 8 data bits LSB first, stop bit
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            state     <= ST_IDLE;
            bit_idx   <= '0;
            uart_tx_o <= 1'b1;          // Line idles high
        end else if (load) begin
            state     <= ST_START;
            uart_tx_o <= 1'b0;
        end else if (tick) begin
            case (state)
                ST_START: begin
                    state     <= ST_DATA;
                    bit_idx   <= '0;
                    uart_tx_o <= shreg[0];
                end
                ST_DATA: begin
                    if (bit_idx == 3'd7) begin
                        state     <= ST_STOP;
                        uart_tx_o <= 1'b1;
                    end else begin
                        bit_idx   <= bit_idx + 3'd1;
                        uart_tx_o <= shreg[0];
                    end
                end
                ST_STOP: state <= ST_IDLE;  // FIFO empty, line stays high
                default: ;
            endcase
        end
    end

    // Shift register, bit 0 is the next data bit
    always_ff @(posedge clk) begin
        if (load) shreg <= head_i;
        else if (tick && (state == ST_START || state == ST_DATA))
            shreg <= {1'b0, shreg[7:1]};
    end

endmodule

`default_nettype wire

// File: periph_subsys.sv
// ---------------------------------------------------------------------------
// Peripheral subsystem top, register block, GPIO, TX FIFO and UART TX
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_subsys (
    input  logic                                  clk,
    input  logic                                  rstz,
    input  periph_types_pkg::bus_req_t            bus_req_i,
    output logic [31:0]                           gpreg_dat_o,
    output logic                                  gpreg_ack_o,
    output logic [23:0]                           bootvec_o,
    input  logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
    output logic [periph_map_pkg::GPIO_WIDTH-1:0] gpio_out_o,
    output logic                                  uart_tx_o
);
    import periph_map_pkg::*;
    import periph_types_pkg::*;

    gpio_ctrl_t            gpio_ctrl;
    logic [GPIO_WIDTH-1:0] gpio_read;
    uart_ctrl_t            uart_ctrl;
    uart_status_t          uart_status;
    logic                  fifo_pop;
    logic [7:0]            fifo_head;

    periph_gpreg gpreg0 (
        .clk          (clk),
        .rstz         (rstz),
        .bus_req_i    (bus_req_i),
        .gpreg_dat_o  (gpreg_dat_o),
        .gpreg_ack_o  (gpreg_ack_o),
        .gpio_ctrl_o  (gpio_ctrl),
        .gpio_read_i  (gpio_read),
        .uart_ctrl_o  (uart_ctrl),
        .uart_status_i(uart_status),
        .bootvec_o    (bootvec_o)
    );

    periph_gpio gpio0 (
        .clk        (clk),
        .rstz       (rstz),
        .gpio_ctrl_i(gpio_ctrl),
        .gpio_in_i  (gpio_in_i),
        .gpio_oe_o  (gpio_oe_o),
        .gpio_out_o (gpio_out_o),
        .gpio_read_o(gpio_read)
    );

    periph_uart_fifo fifo0 (
        .clk          (clk),
        .rstz         (rstz),
        .uart_ctrl_i  (uart_ctrl),
        .pop_i        (fifo_pop),
        .head_o       (fifo_head),
        .uart_status_o(uart_status)
    );

    periph_uart_tx tx0 (
        .clk         (clk),
        .rstz        (rstz),
        .prescaler_i (uart_ctrl.prescaler),
        .fifo_empty_i(uart_status.tx_empty),
        .head_i      (fifo_head),
        .pop_o       (fifo_pop),
        .uart_tx_o   (uart_tx_o)
    );

endmodule

`default_nettype wire

// File: periph_subsys_tb.sv
// ---------------------------------------------------------------------------
// Testbench for the peripheral subsystem, table-driven bus accesses,
// UART line decoder, LFSR stimulus and watchdog
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module periph_subsys_tb;
    import periph_map_pkg::*;
    import periph_types_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_ROWS   = 80;     // Upper bound on table rows over all tests
    localparam int UART_BYTES = 5;
    localparam int FULL_BYTES = 18;
    localparam int FAST_PRESC = 3;
    localparam int SLOW_PRESC = 99;
    // Reset, bus rows, fast frames, then the slow frame and the quiet wait after it
    localparam int WATCHDOG_CYCLES = 2 * (10 + 4 * MAX_ROWS
        + 10 * (FAST_PRESC + 1) * UART_BYTES + 30 * (SLOW_PRESC + 1));

    localparam logic [1:0] OP_WR      = 2'd0;
    localparam logic [1:0] OP_RD      = 2'd1;
    localparam logic [1:0] OP_RD_SIZE = 2'd2;   // Status read, size at most rdata

    typedef struct packed {
        logic [1:0]  op;
        logic [5:0]  addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
    } row_t;

    logic                  clk;
    logic                  rstz;
    bus_req_t              bus_req;
    logic [31:0]           gpreg_dat;
    logic                  gpreg_ack;
    logic [23:0]           bootvec;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_oe;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic                  uart_tx;

    row_t       table_q[$];
    logic [7:0] rx_q[$];        // Bytes seen on the line
    logic [7:0] exp_q[$];
    logic [15:0] lfsr;
    int          bit_cycles;    // Bit time the decoder uses
    int          errors;
    int          tests_run;
    int          tests_failed;

    periph_subsys dut0 (
        .clk        (clk),
        .rstz       (rstz),
        .bus_req_i  (bus_req),
        .gpreg_dat_o(gpreg_dat),
        .gpreg_ack_o(gpreg_ack),
        .bootvec_o  (bootvec),
        .gpio_in_i  (gpio_in),
        .gpio_oe_o  (gpio_oe),
        .gpio_out_o (gpio_out),
        .uart_tx_o  (uart_tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ---------------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (lsb ? 16'hB400 : 16'h0000);
            v    = {v[30:0], lsb};
        end
        return v;
    endfunction

    // Bit 17 full, bit 16 empty, size below
    function automatic logic [31:0] status_word(input int size, input logic full,
                                                input logic empty);
        logic [31:0] w;
        w       = '0;
        w[15:0] = size[15:0];
        w[16]   = empty;
        w[17]   = full;
        return w;
    endfunction

    // One strobe/ack cycle, ack expected on the edge after the strobe
    task automatic bus_cycle(input logic we, input logic [5:0] word,
                             input logic [31:0] data, output logic [31:0] rdata);
        @(posedge clk);
        #2;
        assert (gpreg_ack === 1'b0) else report_error("ack high before the strobe");
        bus_req.adr = {word, 2'b00};
        bus_req.dat = data;
        bus_req.we  = we;
        bus_req.stb = 1'b1;
        @(posedge clk);
        #2;
        assert (gpreg_ack === 1'b1)
            else report_error($sformatf("no ack one cycle after strobe, word %0d", word));
        rdata       = gpreg_dat;
        bus_req.stb = 1'b0;     // Dropped in the ack cycle
        bus_req.we  = 1'b0;
    endtask

    task automatic add_row(input logic [1:0] op, input logic [5:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata);
        table_q.push_back('{op, addr, wdata, rdata});
    endtask

    // ---------------------------------------------------------------------------
    // Table player
    // ---------------------------------------------------------------------------
    task automatic run_table();
        row_t        r;
        logic [31:0] rd;
        foreach (table_q[i]) begin
            r = table_q[i];
            bus_cycle(r.op == OP_WR, r.addr, r.wdata, rd);
            if (r.op == OP_WR && r.addr == REG_UART_PRESCALER)
                bit_cycles = int'(r.wdata[15:0]) + 1;
            if (r.op == OP_RD)
                assert (rd === r.rdata) else report_error($sformatf(
                    "word %0d read %h, expected %h", r.addr, rd, r.rdata));
            if (r.op == OP_RD_SIZE)
                assert (rd[15:0] <= r.rdata[15:0]) else report_error($sformatf(
                    "FIFO size %0d above %0d", rd[15:0], r.rdata[15:0]));
        end
        table_q.delete();
    endtask

    task automatic wait_rx(input int n, input int max_cycles);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < max_cycles) begin
            @(posedge clk);
            cyc++;
        end
        assert (rx_q.size() >= n) else begin
            $display("timed out after %0d cycles waiting for %0d UART bytes, got %0d",
                     max_cycles, n, rx_q.size());
            errors++;
        end
    endtask

    task automatic compare_rx();
        assert (rx_q.size() == exp_q.size()) else report_error($sformatf(
            "received %0d UART bytes, expected %0d", rx_q.size(), exp_q.size()));
        foreach (exp_q[k]) begin
            if (k < rx_q.size())
                assert (rx_q[k] === exp_q[k]) else report_error($sformatf(
                    "UART byte %0d is %h, expected %h", k, rx_q[k], exp_q[k]));
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ---------------------------------------------------------------------------
    // UART line decoder, samples near mid-bit on the falling clock edge
    // ---------------------------------------------------------------------------
    initial begin : uart_decoder
        logic [7:0] data;
        int         bc;
        int         k;
        @(posedge rstz);
        forever begin
            @(negedge uart_tx);                 // Start bit begins
            bc = bit_cycles;
            repeat ((bc + 1) / 2) @(negedge clk);
            assert (uart_tx === 1'b0) else report_error("UART start bit not low at mid-bit");
            for (k = 0; k < 8; k++) begin
                repeat (bc) @(negedge clk);
                data[k] = uart_tx;              // LSB first
            end
            repeat (bc) @(negedge clk);
            assert (uart_tx === 1'b1) else report_error("UART stop bit not high");
            rx_q.push_back(data);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ---------------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------------
    initial begin : main
        logic [31:0] scratch_val;
        logic [31:0] boot_raw;
        logic [31:0] dir_raw;
        logic [31:0] out_raw;
        logic [31:0] presc_raw;
        logic [15:0] pin_val;
        logic [7:0]  byte_val;
        int          err0;
        int          i;
        clk          = 1'b0;
        rstz         = 1'b0;
        bus_req      = '0;
        gpio_in      = '0;
        lfsr         = 16'd16097;
        bit_cycles   = int'(PRESCALER_RESET) + 1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #2 rstz = 1'b1;

        err0 = errors;
        assert (uart_tx === 1'b1) else report_error("uart_tx_o not high after reset");
        assert (gpio_oe === '0) else report_error("gpio_oe_o not zero after reset");
        add_row(OP_RD, REG_SCRATCH, 32'h0, 32'h0);
        add_row(OP_RD, REG_BOOTVEC, 32'h0, 32'h0);
        add_row(OP_RD, REG_GPIO_DIR, 32'h0, 32'h0);
        add_row(OP_RD, REG_GPIO_WRITE, 32'h0, 32'h0);
        add_row(OP_RD, REG_UART_PRESCALER, 32'h0, 32'(PRESCALER_RESET));
        add_row(OP_RD, REG_UART_STATUS, 32'h0, status_word(0, 1'b0, 1'b1));
        run_table();
        finish_test("reset_values", err0);

        err0        = errors;
        scratch_val = rand_bits(32);
        boot_raw    = rand_bits(32);
        dir_raw     = rand_bits(32);
        out_raw     = rand_bits(32);
        presc_raw   = rand_bits(32);
        add_row(OP_WR, REG_SCRATCH, scratch_val, 32'h0);
        add_row(OP_WR, REG_BOOTVEC, boot_raw, 32'h0);
        add_row(OP_WR, REG_GPIO_DIR, dir_raw, 32'h0);
        add_row(OP_WR, REG_GPIO_WRITE, out_raw, 32'h0);
        add_row(OP_WR, REG_UART_PRESCALER, presc_raw, 32'h0);
        add_row(OP_RD, REG_SCRATCH, 32'h0, scratch_val);
        add_row(OP_RD, REG_BOOTVEC, 32'h0, {8'h0, boot_raw[23:0]});
        add_row(OP_RD, REG_GPIO_DIR, 32'h0, {16'h0, dir_raw[15:0]});
        add_row(OP_RD, REG_GPIO_WRITE, 32'h0, {16'h0, out_raw[15:0]});
        add_row(OP_RD, REG_UART_PRESCALER, 32'h0, {16'h0, presc_raw[15:0]});
        run_table();
        assert (bootvec === boot_raw[23:0]) else report_error("bootvec_o differs from register");
        finish_test("read_write", err0);

        // Read-only writes ignored, dead reads keep the last data
        err0 = errors;
        add_row(OP_WR, REG_GPIO_READ, rand_bits(32), 32'h0);
        add_row(OP_WR, REG_UART_STATUS, rand_bits(32), 32'h0);
        add_row(OP_WR, 6'd63, rand_bits(32), 32'h0);
        add_row(OP_RD, REG_GPIO_READ, 32'h0, 32'h0);
        add_row(OP_RD, REG_UART_STATUS, 32'h0, status_word(0, 1'b0, 1'b1));
        add_row(OP_RD, REG_SCRATCH, 32'h0, scratch_val);
        add_row(OP_RD, REG_UART_CTRL, 32'h0, scratch_val);
        add_row(OP_RD, REG_UART_TXDATA, 32'h0, scratch_val);
        add_row(OP_RD, 6'd9, 32'h0, scratch_val);
        add_row(OP_RD, 6'd63, 32'h0, scratch_val);
        run_table();
        finish_test("dead_addresses", err0);

        err0    = errors;
        dir_raw = rand_bits(32);
        out_raw = rand_bits(32);
        add_row(OP_WR, REG_GPIO_DIR, dir_raw, 32'h0);
        add_row(OP_WR, REG_GPIO_WRITE, out_raw, 32'h0);
        add_row(OP_RD, REG_GPIO_DIR, 32'h0, {16'h0, dir_raw[15:0]});
        add_row(OP_RD, REG_GPIO_WRITE, 32'h0, {16'h0, out_raw[15:0]});
        run_table();
        assert (gpio_oe === dir_raw[15:0]) else report_error("gpio_oe_o differs from direction");
        assert (gpio_out === out_raw[15:0]) else report_error("gpio_out_o differs from output");
        pin_val = 16'(rand_bits(16));
        gpio_in = pin_val;
        repeat (2) @(posedge clk);          // Synchronizer depth
        #2;
        add_row(OP_RD, REG_GPIO_READ, 32'h0, {16'h0, pin_val});
        run_table();
        finish_test("gpio", err0);

        err0 = errors;
        add_row(OP_WR, REG_UART_PRESCALER, 32'(FAST_PRESC), 32'h0);
        for (i = 0; i < UART_BYTES; i++) begin
            byte_val = 8'(rand_bits(8));
            exp_q.push_back(byte_val);
            add_row(OP_WR, REG_UART_TXDATA, {24'h0, byte_val}, 32'h0);
            add_row(OP_RD_SIZE, REG_UART_STATUS, 32'h0, 32'(UART_BYTES));
        end
        run_table();
        wait_rx(UART_BYTES, 10 * (FAST_PRESC + 1) * UART_BYTES + 100);
        add_row(OP_RD, REG_UART_STATUS, 32'h0, status_word(0, 1'b0, 1'b1));
        run_table();
        compare_rx();
        finish_test("uart_frames", err0);

        // Slow line so the FIFO fills behind the first frame
        err0 = errors;
        add_row(OP_WR, REG_UART_PRESCALER, 32'(SLOW_PRESC), 32'h0);
        for (i = 0; i < FULL_BYTES; i++) begin
            byte_val = 8'(rand_bits(8));
            if (i == 0)
                exp_q.push_back(byte_val);  // Only the frame in flight survives
            add_row(OP_WR, REG_UART_TXDATA, {24'h0, byte_val}, 32'h0);
        end
        add_row(OP_RD, REG_UART_STATUS, 32'h0, status_word(UART_FIFO_DEPTH, 1'b1, 1'b0));
        add_row(OP_WR, REG_UART_CTRL, 32'h1, 32'h0);
        add_row(OP_RD, REG_UART_STATUS, 32'h0, status_word(0, 1'b0, 1'b1));
        run_table();
        wait_rx(1, 12 * (SLOW_PRESC + 1));
        repeat (20 * (SLOW_PRESC + 1)) @(posedge clk);
        compare_rx();
        assert (uart_tx === 1'b1) else report_error("uart_tx_o not idle after clear");
        finish_test("fifo_full_clear", err0);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: periph_subsys.f
periph_map_pkg.sv
periph_types_pkg.sv
periph_gpreg.sv
periph_gpio.sv
periph_uart_fifo.sv
periph_uart_tx.sv
periph_subsys.sv
periph_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module periph_subsys_tb -Mdir obj_dir -f periph_subsys.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vperiph_subsys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
exit 1
